/* verilog.f */
+incdir+src
src/ipod_pkg.sv
src/key_command_fsm.sv
src/sample_rate_ctrl.sv
src/word_address_gen.sv
src/flash_read_seq.sv
src/simple_ipod.sv
tb/simple_ipod_checker.sv
tb/simple_ipod_tb.sv

/* Bender.yml */
package:
  name: simple_ipod

sources:
  - include_dirs:
      - src
    files:
      - src/ipod_pkg.sv
      - src/key_command_fsm.sv
      - src/sample_rate_ctrl.sv
      - src/word_address_gen.sv
      - src/flash_read_seq.sv
      - src/simple_ipod.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/simple_ipod_checker.sv
      - tb/simple_ipod_tb.sv

/* tb/simple_ipod_tb.sv */
`timescale 1ns/1ns

`include "ipod_params.svh"

module simple_ipod_tb;
  import ipod_pkg::*;

  localparam int tb_base_period = 200;
  localparam int wait_limit     = 8000;

  logic        CLK_50M;
  logic        rst;
  logic [7:0]  key_ascii;
  logic        speed_up;
  logic        speed_down;
  logic        speed_rst;
  logic        flash_waitrequest;
  flash_word_t flash_readdata;
  logic        flash_readdatavalid;
  logic        flash_read;
  flash_addr_t flash_address;
  sample_t     audio_sample;
  logic        sample_valid;

  // Reference model state
  play_state_t m_play;
  dir_t        m_dir;
  flash_addr_t m_addr;
  int          m_period;
  int          prev_period;
  bit          have_prev;

  logic [31:0] stim_rng;
  logic [31:0] flash_rng;
  longint      cycle = 0;
  longint      last_rise;
  string       test_name;
  int          test_count = 0;
  int          check_count = 0;
  int          fail_count = 0;
  int          test_fails = 0;

  simple_ipod #(.base_period(tb_base_period)) simple_ipod_i (.*);

  function automatic logic [31:0] lcg(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper LCG bits, since the low bits repeat quickly
  function automatic logic [15:0] next_rand();
    stim_rng = lcg(stim_rng);
    return stim_rng[31:16];
  endfunction

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  always @(posedge CLK_50M)
    cycle <= cycle + 1;

  // ==============================
  // Flash model
  // ==============================
  initial
  begin
    flash_addr_t rd_addr;
    flash_waitrequest   = 1'b1;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
    flash_rng           = lcg(32'h999c);
    forever
    begin
      @(negedge CLK_50M);
      if (flash_read)
      begin
        rd_addr   = flash_address;
        flash_rng = lcg(flash_rng);
        repeat (flash_rng[17:16]) @(negedge CLK_50M);
        flash_waitrequest = 1'b0;
        @(negedge CLK_50M);
        flash_waitrequest = 1'b1;
        repeat (flash_rng[25:24]) @(negedge CLK_50M);
        flash_readdata      = lcg(32'(rd_addr));
        flash_readdatavalid = 1'b1;
        @(negedge CLK_50M);
        flash_readdatavalid = 1'b0;
      end
    end
  end

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    assert (act === exp)
    else
    begin
      $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_fails++;
    end
  endtask

  task automatic wait_level(input bit pick_valid, input logic level);
    int n;
    n = 0;
    while (((pick_valid ? sample_valid : flash_read) !== level) && (n < wait_limit))
    begin
      n++;
      @(negedge CLK_50M);
    end
    if ((pick_valid ? sample_valid : flash_read) !== level)
    begin
      $display("timeout in %s, %s never reached %b", test_name,
               pick_valid ? "sample_valid" : "flash_read", level);
      $display("Test failures found");
      $finish;
    end
  endtask

  // One read with its spacing, address and captured sample
  task automatic take_sample();
    logic [31:0] word;
    wait_level(1'b0, 1'b0);
    wait_level(1'b0, 1'b1);
    if (m_play == PLAYING && m_dir == FORWARD)
      m_addr = (m_addr == `IPOD_LAST_ADDR) ? '0 : m_addr + 1'b1;
    else if (m_play == PLAYING)
      m_addr = (m_addr == '0) ? `IPOD_LAST_ADDR : m_addr - 1'b1;
    if (have_prev)
      check_val("read spacing", prev_period, cycle - last_rise);
    have_prev   = 1'b1;
    prev_period = m_period;
    last_rise   = cycle;
    check_val("address", m_addr, flash_address);
    word = lcg(32'(m_addr));
    wait_level(1'b1, 1'b1);
    check_val("sample", m_addr[0] ? word[31:16] : word[15:0], audio_sample);
  endtask

  task automatic press(input logic [7:0] code);
    key_ascii = code;
    repeat (2) @(negedge CLK_50M);
    key_ascii = 8'h00;
    @(negedge CLK_50M);
    case (code)
      KEY_E: m_play = PLAYING;
      KEY_D: m_play = PAUSED;
      KEY_F: m_dir = FORWARD;
      KEY_B: m_dir = BACKWARD;
      KEY_R: m_addr = (m_dir == FORWARD) ? '0 : `IPOD_LAST_ADDR;
    endcase
  endtask

  // kind 0 is speed up, 1 speed down, else speed reset
  task automatic pulse_speed(input int kind, input int count);
    repeat (count)
    begin
      case (kind)
        0: speed_up = 1'b1;
        1: speed_down = 1'b1;
        default: speed_rst = 1'b1;
      endcase
      @(negedge CLK_50M);
      speed_up   = 1'b0;
      speed_down = 1'b0;
      speed_rst  = 1'b0;
      @(negedge CLK_50M);
      case (kind)
        0: m_period = (m_period - `IPOD_SPEED_STEP < `IPOD_MIN_PERIOD) ?
                      `IPOD_MIN_PERIOD : m_period - `IPOD_SPEED_STEP;
        1: m_period = (m_period + `IPOD_SPEED_STEP > `IPOD_MAX_PERIOD) ?
                      `IPOD_MAX_PERIOD : m_period + `IPOD_SPEED_STEP;
        default: m_period = tb_base_period;
      endcase
    end
  endtask

  task automatic finish_test();
    test_count++;
    fail_count += test_fails;
    if (test_fails == 0)
      $display("test %s: ok", test_name);
    else
      $display("test %s: %0d failed checks", test_name, test_fails);
    test_fails = 0;
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial
  begin
    int pick;
    key_ascii   = 8'h00;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_rst   = 1'b0;
    stim_rng    = 32'h999c;
    m_play      = PAUSED;
    m_dir       = FORWARD;
    m_addr      = '0;
    m_period    = tb_base_period;
    prev_period = tb_base_period;
    have_prev   = 1'b0;
    rst         = 1'b1;
    repeat (16) @(negedge CLK_50M);
    rst = 1'b0;

    test_name = "reset_idle";
    repeat (4) take_sample();
    finish_test();

    test_name = "play_forward";
    press(KEY_E);
    press(KEY_F);
    repeat (6) take_sample();
    finish_test();

    // Paused restart so the first read lands on the last word
    test_name = "backward_wrap";
    press(KEY_D);
    press(KEY_B);
    press(KEY_R);
    take_sample();
    check_val("restart address", `IPOD_LAST_ADDR, flash_address);
    press(KEY_E);
    repeat (3) take_sample();
    press(KEY_F);
    repeat (5) take_sample();
    press(KEY_B);
    repeat (2) take_sample();
    finish_test();

    test_name = "pause_hold";
    press(KEY_D);
    repeat (4) take_sample();
    finish_test();

    test_name = "speed_change";
    pulse_speed(0, 1 + next_rand() % 6);
    repeat (3) take_sample();
    pulse_speed(0, 12);
    repeat (3) take_sample();
    pulse_speed(1, 1 + next_rand() % 8);
    repeat (3) take_sample();
    pulse_speed(2, 1);
    repeat (3) take_sample();
    finish_test();

    test_name = "random_mix";
    repeat (40)
    begin
      pick = next_rand() % 9;
      case (pick)
        0: press(KEY_E);
        1: press(KEY_D);
        2: press(KEY_F);
        3: press(KEY_B);
        4: press(KEY_R);
        5: pulse_speed(0, 1 + next_rand() % 4);
        6: pulse_speed(1, 1 + next_rand() % 4);
        7: pulse_speed(2, 1);
        default: press(8'h41);
      endcase
      take_sample();
    end
    finish_test();

    fail_count += simple_ipod_i.ipod_checker_i.assert_errors;
    $display("summary: %0d tests, %0d checks, %0d checker failures, %0d failed in total",
             test_count, check_count, simple_ipod_i.ipod_checker_i.assert_errors, fail_count);
    if (fail_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* tb/simple_ipod_checker.sv */
`timescale 1ns/1ns

module simple_ipod_checker (
  input logic                  CLK_50M,
  input logic                  rst,
  input logic                  flash_read,
  input logic                  flash_waitrequest,
  input logic                  flash_readdatavalid,
  input ipod_pkg::flash_addr_t flash_address,
  input logic                  sample_valid
);

  int   assert_errors = 0;
  logic read_pending;

  // An accepted read stays pending until its sample is out
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      read_pending <= 1'b0;
    else if (flash_read && !flash_waitrequest)
      read_pending <= 1'b1;
    else if (sample_valid)
      read_pending <= 1'b0;
  end

  // ==============================
  // Flash handshake
  // ==============================
  request_held: assert property (@(posedge CLK_50M) disable iff (rst)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address))
  else
  begin
    $error("flash read request dropped or changed while waitrequest was high");
    assert_errors++;
  end

  // ==============================
  // Sample strobe
  // ==============================
  strobe_single: assert property (@(posedge CLK_50M) disable iff (rst)
    sample_valid |=> !sample_valid)
  else
  begin
    $error("sample_valid stayed high for two cycles");
    assert_errors++;
  end

  strobe_after_read: assert property (@(posedge CLK_50M) disable iff (rst)
    sample_valid |-> read_pending && $past(flash_readdatavalid))
  else
  begin
    $error("sample_valid without an accepted read and its data");
    assert_errors++;
  end

endmodule

bind simple_ipod simple_ipod_checker ipod_checker_i (.*);

/* src/simple_ipod.sv */
`timescale 1ns/1ns

`include "ipod_params.svh"

module simple_ipod #(
  parameter int unsigned base_period = `IPOD_BASE_PERIOD
) (
  input  logic                   CLK_50M,
  input  logic                   rst,
  input  logic [7:0]             key_ascii,
  input  logic                   speed_up,
  input  logic                   speed_down,
  input  logic                   speed_rst,
  input  logic                   flash_waitrequest,
  input  ipod_pkg::flash_word_t  flash_readdata,
  input  logic                   flash_readdatavalid,
  output logic                   flash_read,
  output ipod_pkg::flash_addr_t  flash_address,
  output ipod_pkg::sample_t      audio_sample,
  output logic                   sample_valid
);
  import ipod_pkg::*;

  play_state_t play_state;
  dir_t        dir;
  logic        restart;
  logic        sample_tick;
  logic        addr_step;

  // ==============================
  // Input side
  // ==============================
  key_command_fsm key_command_fsm_i (
    .CLK_50M    (CLK_50M),
    .rst        (rst),
    .key_ascii  (key_ascii),
    .play_state (play_state),
    .dir        (dir),
    .restart    (restart)
  );

  sample_rate_ctrl #(
    .base_period (base_period)
  ) sample_rate_ctrl_i (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_rst   (speed_rst),
    .sample_tick (sample_tick)
  );

  // ==============================
  // Address and flash reads
  // ==============================
  word_address_gen word_address_gen_i (
    .CLK_50M    (CLK_50M),
    .rst        (rst),
    .addr_step  (addr_step),
    .play_state (play_state),
    .dir        (dir),
    .restart    (restart),
    .address    (flash_address)
  );

  flash_read_seq flash_read_seq_i (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .sample_tick         (sample_tick),
    .address             (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .addr_step           (addr_step),
    .flash_read          (flash_read),
    .audio_sample        (audio_sample),
    .sample_valid        (sample_valid)
  );

endmodule

/* src/flash_read_seq.sv */
`timescale 1ns/1ns

`include "ipod_params.svh"

module flash_read_seq (
  input  logic                   CLK_50M,
  input  logic                   rst,
  input  logic                   sample_tick,
  input  ipod_pkg::flash_addr_t  address,
  input  logic                   flash_waitrequest,
  input  ipod_pkg::flash_word_t  flash_readdata,
  input  logic                   flash_readdatavalid,
  output logic                   addr_step,
  output logic                   flash_read,
  output ipod_pkg::sample_t      audio_sample,
  output logic                   sample_valid
);
  import ipod_pkg::*;

  flash_state_t state;
  logic         sel_upper;
  logic         read_accept;
  logic         data_done;

  assign addr_step   = (state == ADVANCE);
  assign flash_read  = (state == READ);
  assign read_accept = flash_read && !flash_waitrequest;
  assign data_done   = (state == WAIT) && flash_readdatavalid;

  // ==============================
  // Step, read, wait
  // ==============================

  // Ticks outside IDLE are dropped, one read in flight
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      state <= IDLE;
    else
    begin
      case (state)
        IDLE:    if (sample_tick) state <= ADVANCE;
        ADVANCE: state <= READ;
        READ:    if (!flash_waitrequest) state <= WAIT;
        WAIT:    if (flash_readdatavalid) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Half select taken from the address the read went out with
  always_ff @(posedge CLK_50M)
  begin
    if (read_accept)
      sel_upper <= address[0];
  end

  // ==============================
  // Sample capture
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      sample_valid <= 1'b0;
      audio_sample <= '0;
    end
    else
    begin
      sample_valid <= data_done;
      if (data_done)
        audio_sample <= sel_upper ? flash_readdata[`IPOD_WORD_W-1 -: `IPOD_SAMPLE_W]
                                  : flash_readdata[`IPOD_SAMPLE_W-1:0];
    end
  end

endmodule

/* src/word_address_gen.sv */
`timescale 1ns/1ns

`include "ipod_params.svh"

module word_address_gen (
  input  logic                   CLK_50M,
  input  logic                   rst,
  input  logic                   addr_step,
  input  ipod_pkg::play_state_t  play_state,
  input  ipod_pkg::dir_t         dir,
  input  logic                   restart,
  output ipod_pkg::flash_addr_t  address
);
  import ipod_pkg::*;

  localparam flash_addr_t last_addr = `IPOD_LAST_ADDR;

  // Restart wins over stepping, and ignores the play state
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      address <= '0;
    else if (restart)
    begin
      if (dir == FORWARD)
        address <= '0;
      else
        address <= last_addr;
    end
    else if (addr_step && (play_state == PLAYING))
    begin
      if (dir == FORWARD)
      begin
        // Wrap past the end of the recording
        if (address == last_addr)
          address <= '0;
        else
          address <= address + 1'b1;
      end
      else
      begin
        if (address == '0)
          address <= last_addr;
        else
          address <= address - 1'b1;
      end
    end
  end

endmodule

/* src/sample_rate_ctrl.sv */
`timescale 1ns/1ns

`include "ipod_params.svh"

module sample_rate_ctrl #(
  parameter int unsigned base_period = `IPOD_BASE_PERIOD
) (
  input  logic CLK_50M,
  input  logic rst,
  input  logic speed_up,
  input  logic speed_down,
  input  logic speed_rst,
  output logic sample_tick
);
  import ipod_pkg::*;

  localparam period_t period_base = period_t'(base_period);
  localparam period_t period_step = period_t'(`IPOD_SPEED_STEP);
  localparam period_t period_min  = period_t'(`IPOD_MIN_PERIOD);
  localparam period_t period_max  = period_t'(`IPOD_MAX_PERIOD);

  period_t period;
  period_t count;

  // ==============================
  // Adjustable period
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (rst || speed_rst)
      period <= period_base;
    else if (speed_up)
    begin
      // Shorter period, faster playback
      if (period < period_min + period_step)
        period <= period_min;
      else
        period <= period - period_step;
    end
    else if (speed_down)
    begin
      if (period > period_max - period_step)
        period <= period_max;
      else
        period <= period + period_step;
    end
  end

  // ==============================
  // Tick counter
  // ==============================

  // Reload from the period held at the tick, so spacing is exact
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      count       <= '0;
      sample_tick <= 1'b0;
    end
    else if (count == '0)
    begin
      count       <= period - 1'b1;
      sample_tick <= 1'b1;
    end
    else
    begin
      count       <= count - 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

/* src/key_command_fsm.sv */
`timescale 1ns/1ns

module key_command_fsm (
  input  logic                   CLK_50M,
  input  logic                   rst,
  input  logic [7:0]             key_ascii,
  output ipod_pkg::play_state_t  play_state,
  output ipod_pkg::dir_t         dir,
  output logic                   restart
);
  import ipod_pkg::*;

  // ==============================
  // Key decoding
  // ==============================

  // Play state and direction are sticky, restart follows the key level
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      play_state <= PAUSED;
      dir        <= FORWARD;
      restart    <= 1'b0;
    end
    else
    begin
      restart <= (key_ascii == KEY_R);
      case (key_ascii)
        KEY_E:
        begin
          play_state <= PLAYING;
        end
        KEY_D:
        begin
          play_state <= PAUSED;
        end
        KEY_F:
        begin
          dir <= FORWARD;
        end
        KEY_B:
        begin
          dir <= BACKWARD;
        end
        default:
        begin
          // Any other key leaves the state alone
          play_state <= play_state;
        end
      endcase
    end
  end

endmodule

/* src/ipod_pkg.sv */
`include "ipod_params.svh"

package ipod_pkg;

  typedef logic [`IPOD_ADDR_W-1:0]   flash_addr_t;
  typedef logic [`IPOD_WORD_W-1:0]   flash_word_t;
  typedef logic [`IPOD_SAMPLE_W-1:0] sample_t;
  typedef logic [`IPOD_PERIOD_W-1:0] period_t;

  // ASCII codes of the command keys
  typedef enum logic [7:0] {
    KEY_B = 8'h42,
    KEY_D = 8'h44,
    KEY_E = 8'h45,
    KEY_F = 8'h46,
    KEY_R = 8'h52
  } key_cmd_t;

  typedef enum logic {PAUSED, PLAYING} play_state_t;
  typedef enum logic {FORWARD, BACKWARD} dir_t;

  typedef enum logic [1:0] {IDLE, ADVANCE, READ, WAIT} flash_state_t;

endpackage

/* src/ipod_params.svh */
`ifndef IPOD_PARAMS_SVH
`define IPOD_PARAMS_SVH

// ==============================
// Flash and sample widths
// ==============================
`define IPOD_ADDR_W   23
`define IPOD_WORD_W   32
`define IPOD_SAMPLE_W 16
`define IPOD_PERIOD_W 16

// Last word of the recording
`define IPOD_LAST_ADDR 23'h7FFFF

// ==============================
// Sample period in clock cycles
// ==============================
`define IPOD_BASE_PERIOD 22000
`define IPOD_SPEED_STEP  16
`define IPOD_MIN_PERIOD  32
`define IPOD_MAX_PERIOD  65000

`endif
